// File: design/rp_analog_pkg.sv
package rp_analog_pkg;

  //////////////////////////////////////////////////////////////////////
  // channel and sample geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned CH_NUM    = 2;          // analog channels, a and b
  localparam int unsigned DAT_W     = 14;         // adc, asg, pid and dac words
  localparam int unsigned SUM_W     = DAT_W + 1;  // asg + pid with one growth bit
  localparam int unsigned ADC_SHIFT = 2;          // low adc bits dropped by the scale

  // split of the sum word for the saturation check
  localparam int unsigned GUARD_W = 2;                // top two bits of the sum
  localparam int unsigned BODY_W  = SUM_W - GUARD_W;  // remaining magnitude bits

  //////////////////////////////////////////////////////////////////////
  // dac sum word
  //////////////////////////////////////////////////////////////////////

  // one 15 bit word, read two ways
  //   val   signed view, written by the adder
  //   fld   guard over body, read by the clamp
  //
  // guard 00 or 11  -> sum fits in DAT_W, result is {guard[0], body}
  // guard 01        -> positive overflow, result is 0 followed by ones
  // guard 10        -> negative overflow, result is 1 followed by zeros
  //
  // so on overflow the output is guard[1] then BODY_W copies of ~guard[1]
  typedef union packed {
    logic signed [SUM_W-1:0] val;  // arithmetic view
    struct packed {
      logic [GUARD_W-1:0] guard;   // sign and growth bit
      logic [BODY_W-1:0]  body;    // low bits, passed on when no clamp
    } fld;
  } dac_sum_u;

  // worked limits for DAT_W = 14
  //   largest positive word  14'h1fff  ( 8191)
  //   most negative word     14'h2000  (-8192)
  //   sum range              -16384 .. 16382

  // adc scale for DAT_W = 14, ADC_SHIFT = 2
  //   14'h1fff -> 14'h07ff
  //   14'h2000 -> 14'h3800
  //   14'h3fff -> 14'h3fff, minus one stays minus one

endpackage

// File: design/adc_frontend.sv
module adc_frontend (
  input  logic                                                      adc_clk,
  input  logic                                                      arst_n_i,
  // raw two's complement words, one per channel
  input  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] adc_dat_i,
  // scaled words, sign extended over the dropped bits
  output logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] adc_scl_o
);

  //////////////////////////////////////////////////////////////////////
  // capture and scale
  //////////////////////////////////////////////////////////////////////

  // first register after the pins, scale folded into its input
  // arithmetic shift right by ADC_SHIFT, top filled with sign copies
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      adc_scl_o <= '0;  // all channels read zero in reset
    end
    else
    begin
      for (int ch = 0; ch < rp_analog_pkg::CH_NUM; ch++)
      begin
        adc_scl_o[ch] <= {
          {rp_analog_pkg::ADC_SHIFT{adc_dat_i[ch][rp_analog_pkg::DAT_W-1]}},  // sign copies
          adc_dat_i[ch][rp_analog_pkg::DAT_W-1:rp_analog_pkg::ADC_SHIFT]       // kept bits
        };
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // the sign copies plus the shifted sign bit must all agree
  // covers bits DAT_W-1 down to DAT_W-ADC_SHIFT-1
  for (genvar ch = 0; ch < rp_analog_pkg::CH_NUM; ch++)
  begin : g_chk
    a_sign_ext : assert property (
      @(posedge adc_clk) disable iff (!arst_n_i)
      adc_scl_o[ch][rp_analog_pkg::DAT_W-1:rp_analog_pkg::DAT_W-rp_analog_pkg::ADC_SHIFT-1]
        == {(rp_analog_pkg::ADC_SHIFT+1){adc_scl_o[ch][rp_analog_pkg::DAT_W-1]}}
    )
    else
      $error("adc_frontend: ch %0d scaled word %h not sign extended", ch, adc_scl_o[ch]);
  end

  // note on range
  // a full scale positive input lands at 2**(DAT_W-ADC_SHIFT-1)-1
  // a full scale negative input lands at -2**(DAT_W-ADC_SHIFT-1)
  // so the scaled word never reaches the dac clamp limits

endmodule

// File: design/analog_channel.sv
module analog_channel (
  input  logic                                   adc_clk,
  input  logic                                   arst_n_i,
  // generator and controller samples
  input  logic signed [rp_analog_pkg::DAT_W-1:0] asg_i,
  input  logic signed [rp_analog_pkg::DAT_W-1:0] pid_i,
  // scaled adc word from the front end
  input  logic        [rp_analog_pkg::DAT_W-1:0] adc_scl_i,
  input  logic                                   digital_loop_i,  // 1 = dac back into acq
  output logic        [rp_analog_pkg::DAT_W-1:0] dac_o,           // clamped dac word
  output logic        [rp_analog_pkg::DAT_W-1:0] smp_o            // acquisition sample
);

  rp_analog_pkg::dac_sum_u           dac_sum;  // asg + pid, SUM_W wide
  logic                              dac_sat;  // guard bits disagree
  logic [rp_analog_pkg::DAT_W-1:0]   dac_nxt;  // clamped sum, before the register

  //////////////////////////////////////////////////////////////////////
  // sum and clamp
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // signed operands, so both are sign extended to SUM_W before the add
    dac_sum.val = asg_i + pid_i;

    // overflow out of DAT_W shows up as differing guard bits
    dac_sat = ^dac_sum.fld.guard;

    if (dac_sat)
    begin
      // pin to the limit on the side of the true sign
      dac_nxt = {dac_sum.fld.guard[1], {rp_analog_pkg::BODY_W{~dac_sum.fld.guard[1]}}};
    end
    else
    begin
      dac_nxt = {dac_sum.fld.guard[0], dac_sum.fld.body};  // fits, drop the growth bit
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pipeline registers
  //////////////////////////////////////////////////////////////////////

  // stage 1  asg/pid -> dac_o
  // stage 2  adc_scl_i or registered dac_o -> smp_o
  // both stages update on the same edge, so loopback sees the older dac_o
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_o <= '0;
      smp_o <= '0;
    end
    else
    begin
      dac_o <= dac_nxt;
      if (digital_loop_i)
      begin
        smp_o <= dac_o;      // loopback, takes the already registered word
      end
      else
      begin
        smp_o <= adc_scl_i;  // normal acquisition
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // clamped output one cycle later keeps the sign of the full sum
  a_clamp_sign : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    dac_sat |=> (dac_o[rp_analog_pkg::DAT_W-1] == $past(dac_sum.fld.guard[1]))
  )
  else
    $error("analog_channel: clamp flipped sign, dac_o = %h", dac_o);

  // loop on: the acquisition word is the dac word of the cycle before
  a_loop_path : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    digital_loop_i |=> (smp_o == $past(dac_o))
  )
  else
    $error("analog_channel: loopback sample %h does not follow dac word", smp_o);

  // latency summary
  //   asg/pid   -> dac_o  1 cycle
  //   adc_scl_i -> smp_o  1 cycle
  //   asg/pid   -> smp_o  2 cycles in loopback

endmodule

// File: design/dac_backend.sv
module dac_backend (
  input  logic                                                       adc_clk,
  input  logic                                                       arst_n_i,
  // per channel words from the analog channels
  input  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] ch_dac_i,
  input  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] ch_smp_i,
  // pin side words
  output logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] dac_dat_o,
  output logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] adc_smp_o,
  output logic                                                       dac_reset_o
);

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  // last flop before the dac pins and the acquisition port
  // dac runs on adc_clk here, no second clock domain
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_o <= '0;  // dac idles at mid scale
      adc_smp_o <= '0;
    end
    else
    begin
      for (int ch = 0; ch < rp_analog_pkg::CH_NUM; ch++)
      begin
        dac_dat_o[ch] <= ch_dac_i[ch];  // channel word into the combined dac bus
        adc_smp_o[ch] <= ch_smp_i[ch];  // channel word into the acquisition bus
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // dac reset
  //////////////////////////////////////////////////////////////////////

  // high at once on reset entry
  // released on the first clock edge after arst_n_i goes high
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_reset_o <= 1'b1;
    end
    else
    begin
      dac_reset_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // no glitch back to reset without a new system reset
  a_dac_reset_low : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    !dac_reset_o |=> !dac_reset_o
  )
  else
    $error("dac_backend: dac_reset_o rose without a system reset");

  // latency summary
  //   ch_dac_i -> dac_dat_o  1 cycle
  //   ch_smp_i -> adc_smp_o  1 cycle

endmodule

// File: design/analog_top.sv
module analog_top (
  input  logic                                                       adc_clk,
  input  logic                                                       arst_n_i,
  // adc words, already captured, two's complement
  input  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] adc_dat_i,
  // generator and controller samples, signed per element
  input  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] asg_dat_i,
  input  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] pid_dat_i,
  input  logic                                                       digital_loop_i,
  // acquisition output
  output logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] adc_smp_o,
  // dac pins
  output logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] dac_dat_o,
  output logic                                                       dac_reset_o
);

  //////////////////////////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////////////////////////

  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] adc_scl;  // scaled adc
  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] ch_dac;   // clamped dac
  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] ch_smp;   // acq select

  //////////////////////////////////////////////////////////////////////
  // adc front end
  //////////////////////////////////////////////////////////////////////

  adc_frontend u_frontend (
    .adc_clk   (adc_clk  ),
    .arst_n_i  (arst_n_i ),
    .adc_dat_i (adc_dat_i),  // raw words in
    .adc_scl_o (adc_scl  )   // 1 cycle later
  );

  //////////////////////////////////////////////////////////////////////
  // analog channels
  //////////////////////////////////////////////////////////////////////

  // one adder, clamp and loopback select per channel
  for (genvar ch = 0; ch < rp_analog_pkg::CH_NUM; ch++)
  begin : g_ch
    analog_channel u_channel (
      .adc_clk        (adc_clk       ),
      .arst_n_i       (arst_n_i      ),
      .asg_i          (asg_dat_i[ch] ),  // generator sample
      .pid_i          (pid_dat_i[ch] ),  // controller sample
      .adc_scl_i      (adc_scl[ch]   ),
      .digital_loop_i (digital_loop_i),  // shared by both channels
      .dac_o          (ch_dac[ch]    ),
      .smp_o          (ch_smp[ch]    )
    );
  end

  //////////////////////////////////////////////////////////////////////
  // dac and acquisition back end
  //////////////////////////////////////////////////////////////////////

  dac_backend u_backend (
    .adc_clk     (adc_clk    ),
    .arst_n_i    (arst_n_i   ),
    .ch_dac_i    (ch_dac     ),
    .ch_smp_i    (ch_smp     ),
    .dac_dat_o   (dac_dat_o  ),  // 2 cycles from asg/pid
    .adc_smp_o   (adc_smp_o  ),  // 3 cycles from adc_dat_i
    .dac_reset_o (dac_reset_o)
  );

  // end to end
  //   asg/pid        -> dac_dat_o  2 cycles
  //   adc_dat_i      -> adc_smp_o  3 cycles
  //   asg/pid        -> adc_smp_o  3 cycles in loopback
  //   digital_loop_i -> adc_smp_o  2 cycles

endmodule

// File: include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns  adc a, adc b, asg a, asg b, pid a, pid b, loop
//          then expected smp a, smp b, dac a, dac b
// all words 14 bit two's complement, channel a is index 0
localparam int unsigned TBL_ROWS = 11;

function automatic vec_t table_row(input int unsigned idx);
  vec_t r;
  r = '0;
  case (idx)
    0  : r = {14'h0100, 14'h3f00, 14'h0100, 14'h3ff0, 14'h0023, 14'h0005, 1'b0,
              14'h0040, 14'h3fc0, 14'h0123, 14'h3ff5};  // small, mixed signs
    1  : r = {14'h1fff, 14'h2000, 14'h0000, 14'h1000, 14'h0000, 14'h0fff, 1'b0,
              14'h07ff, 14'h3800, 14'h0000, 14'h1fff};  // adc full scale, b sum at limit
    2  : r = {14'h3fff, 14'h0003, 14'h1fff, 14'h2000, 14'h0001, 14'h3fff, 1'b0,
              14'h3fff, 14'h0000, 14'h1fff, 14'h2000};  // minus one, both clamp by one
    3  : r = {14'h0004, 14'h3ffc, 14'h1fff, 14'h2000, 14'h1fff, 14'h2000, 1'b0,
              14'h0001, 14'h3fff, 14'h1fff, 14'h2000};  // widest sums
    4  : r = {14'h1234, 14'h2abc, 14'h1800, 14'h0800, 14'h0900, 14'h3800, 1'b0,
              14'h048d, 14'h3aaf, 14'h1fff, 14'h0000};  // a clamps high, b fits
    5  : r = {14'h0000, 14'h3fff, 14'h2800, 14'h0abc, 14'h3000, 14'h0001, 1'b0,
              14'h0000, 14'h3fff, 14'h2000, 14'h0abd};  // a clamps low, b fits
    6  : r = {14'h1fff, 14'h2000, 14'h0555, 14'h3e00, 14'h0111, 14'h3f00, 1'b1,
              14'h0666, 14'h3d00, 14'h0666, 14'h3d00};  // loopback, plain sums
    7  : r = {14'h1234, 14'h0fff, 14'h1fff, 14'h2001, 14'h1000, 14'h3ffe, 1'b1,
              14'h1fff, 14'h2000, 14'h1fff, 14'h2000};  // loopback of clamped words
    8  : r = {14'h0fff, 14'h3000, 14'h3fff, 14'h0000, 14'h0001, 14'h3fff, 1'b0,
              14'h03ff, 14'h3c00, 14'h0000, 14'h3fff};  // back to adc path
    9  : r = {14'h3fff, 14'h3fff, 14'h2000, 14'h1fff, 14'h0000, 14'h0000, 1'b1,
              14'h2000, 14'h1fff, 14'h2000, 14'h1fff};  // loopback, extremes
    10 : r = {14'h0000, 14'h0000, 14'h0000, 14'h0000, 14'h0000, 14'h0000, 1'b0,
              14'h0000, 14'h0000, 14'h0000, 14'h0000};  // idle
    default : r = '0;
  endcase
  return r;
endfunction

`endif

// File: verif/tb_analog_top.sv
module tb_analog_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned HOLD_CYC  = 5;   // cycles each row is held
  localparam int unsigned RAND_ROWS = 40;
  localparam int unsigned RST_CYC   = 10;

  localparam logic [rp_analog_pkg::DAT_W-1:0] STEP_A = 14'h0a5a;  // latency step, a
  localparam logic [rp_analog_pkg::DAT_W-1:0] STEP_B = 14'h35a5;  // negative step, b

  // one stimulus row with its expected outputs
  typedef struct packed {
    logic [rp_analog_pkg::DAT_W-1:0] adc_a;
    logic [rp_analog_pkg::DAT_W-1:0] adc_b;
    logic [rp_analog_pkg::DAT_W-1:0] asg_a;
    logic [rp_analog_pkg::DAT_W-1:0] asg_b;
    logic [rp_analog_pkg::DAT_W-1:0] pid_a;
    logic [rp_analog_pkg::DAT_W-1:0] pid_b;
    logic                            loop;
    logic [rp_analog_pkg::DAT_W-1:0] smp_a;
    logic [rp_analog_pkg::DAT_W-1:0] smp_b;
    logic [rp_analog_pkg::DAT_W-1:0] dac_a;
    logic [rp_analog_pkg::DAT_W-1:0] dac_b;
  } vec_t;

  `include "tb_vectors.svh"

  localparam int unsigned MAX_CYC = RST_CYC + (TBL_ROWS + RAND_ROWS) * HOLD_CYC + 20;

  logic                                                       adc_clk;
  logic                                                       arst_n_i;
  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] adc_dat_i;
  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] asg_dat_i;
  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] pid_dat_i;
  logic                                                       digital_loop_i;
  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] adc_smp_o;
  logic [rp_analog_pkg::CH_NUM-1:0][rp_analog_pkg::DAT_W-1:0] dac_dat_o;
  logic                                                       dac_reset_o;

  logic [31:0] lfsr_state = 32'h1b926b0f;
  int unsigned cyc_cnt  = 0;
  int unsigned checks   = 0;
  int unsigned err_cnt  = 0;
  int unsigned err_mark = 0;  // err_cnt when the current test began
  int unsigned test_cnt = 0;
  int unsigned fail_cnt = 0;

  analog_top dut (
    .adc_clk        (adc_clk       ),
    .arst_n_i       (arst_n_i      ),
    .adc_dat_i      (adc_dat_i     ),
    .asg_dat_i      (asg_dat_i     ),
    .pid_dat_i      (pid_dat_i     ),
    .digital_loop_i (digital_loop_i),
    .adc_smp_o      (adc_smp_o     ),
    .dac_dat_o      (dac_dat_o     ),
    .dac_reset_o    (dac_reset_o   )
  );

  //////////////////////////////////////////////////////////////////////
  // clock and run limit
  //////////////////////////////////////////////////////////////////////

  initial adc_clk = 1'b0;
  always #50 adc_clk = ~adc_clk;  // 100 ns period

  always @(posedge adc_clk)
  begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYC)
    begin
      $display("timeout: the run did not finish within %0d clock cycles", MAX_CYC);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int unsigned n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};  // one step per bit
    end
  endtask

  // arithmetic shift of the raw word
  function automatic logic [rp_analog_pkg::DAT_W-1:0] scale_ref(
    input logic [rp_analog_pkg::DAT_W-1:0] raw
  );
    int v;
    v = $signed(raw);
    v = v >>> rp_analog_pkg::ADC_SHIFT;
    return v[rp_analog_pkg::DAT_W-1:0];
  endfunction

  // integer sum, saturated to the signed DAT_W range
  function automatic logic [rp_analog_pkg::DAT_W-1:0] dac_ref(
    input logic [rp_analog_pkg::DAT_W-1:0] asg,
    input logic [rp_analog_pkg::DAT_W-1:0] pid
  );
    int a;
    int b;
    int s;
    int hi;
    a  = $signed(asg);
    b  = $signed(pid);
    s  = a + b;
    hi = 2 ** (rp_analog_pkg::DAT_W - 1) - 1;
    if (s > hi)
    begin
      s = hi;
    end
    else if (s < -hi - 1)
    begin
      s = -hi - 1;
    end
    return s[rp_analog_pkg::DAT_W-1:0];
  endfunction

  task automatic make_rand_row(output vec_t v);
    logic [31:0] bits;
    draw_bits(rp_analog_pkg::DAT_W, bits);
    v.adc_a = bits[rp_analog_pkg::DAT_W-1:0];
    draw_bits(rp_analog_pkg::DAT_W, bits);
    v.adc_b = bits[rp_analog_pkg::DAT_W-1:0];
    draw_bits(rp_analog_pkg::DAT_W, bits);
    v.asg_a = bits[rp_analog_pkg::DAT_W-1:0];
    draw_bits(rp_analog_pkg::DAT_W, bits);
    v.asg_b = bits[rp_analog_pkg::DAT_W-1:0];
    draw_bits(rp_analog_pkg::DAT_W, bits);
    v.pid_a = bits[rp_analog_pkg::DAT_W-1:0];
    draw_bits(rp_analog_pkg::DAT_W, bits);
    v.pid_b = bits[rp_analog_pkg::DAT_W-1:0];
    draw_bits(1, bits);
    v.loop  = bits[0];
    v.dac_a = dac_ref(v.asg_a, v.pid_a);
    v.dac_b = dac_ref(v.asg_b, v.pid_b);
    v.smp_a = v.loop ? v.dac_a : scale_ref(v.adc_a);  // loopback ignores the adc
    v.smp_b = v.loop ? v.dac_b : scale_ref(v.adc_b);
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive and check helpers
  //////////////////////////////////////////////////////////////////////

  task automatic drive_row(input vec_t v);
    adc_dat_i[0]   <= v.adc_a;
    adc_dat_i[1]   <= v.adc_b;
    asg_dat_i[0]   <= v.asg_a;
    asg_dat_i[1]   <= v.asg_b;
    pid_dat_i[0]   <= v.pid_a;
    pid_dat_i[1]   <= v.pid_b;
    digital_loop_i <= v.loop;
  endtask

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs(input string tag, input vec_t v);
    check_val($sformatf("%s adc_smp_o a", tag), adc_smp_o[0], v.smp_a);
    check_val($sformatf("%s adc_smp_o b", tag), adc_smp_o[1], v.smp_b);
    check_val($sformatf("%s dac_dat_o a", tag), dac_dat_o[0], v.dac_a);
    check_val($sformatf("%s dac_dat_o b", tag), dac_dat_o[1], v.dac_b);
  endtask

  task automatic close_test(input string name);
    test_cnt++;
    if (err_cnt != err_mark)
    begin
      fail_cnt++;
      $display("%s: fail, %0d mismatches", name, err_cnt - err_mark);
    end
    else
    begin
      $display("%s: pass", name);
    end
    err_mark = err_cnt;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    vec_t v;
    $timeformat(-9, 0, " ns", 0);
    arst_n_i       = 1'b0;
    adc_dat_i      = '0;
    asg_dat_i      = '0;
    pid_dat_i      = '0;
    digital_loop_i = 1'b0;

    // reset, dac_reset_o high until the first edge after release
    repeat (RST_CYC - 1) @(posedge adc_clk);
    @(negedge adc_clk);
    check_val("dac_reset_o in reset", dac_reset_o, 1'b1);
    check_val("dac_dat_o in reset", dac_dat_o, '0);
    check_val("adc_smp_o in reset", adc_smp_o, '0);
    @(posedge adc_clk);
    arst_n_i       <= 1'b1;
    digital_loop_i <= 1'b1;  // loopback ready for the step test
    @(negedge adc_clk);
    check_val("dac_reset_o before first edge", dac_reset_o, 1'b1);
    @(posedge adc_clk);
    @(negedge adc_clk);
    check_val("dac_reset_o after first edge", dac_reset_o, 1'b0);
    check_val("dac_dat_o after reset", dac_dat_o, '0);
    check_val("adc_smp_o after reset", adc_smp_o, '0);
    close_test("reset");

    // single cycle step, dac after 2 edges, loopback sample after 3
    @(posedge adc_clk);
    asg_dat_i[0] <= STEP_A;
    asg_dat_i[1] <= STEP_B;
    for (int i = 1; i <= 4; i++)
    begin
      @(posedge adc_clk);
      if (i == 1)
      begin
        asg_dat_i <= '0;
      end
      @(negedge adc_clk);
      check_val($sformatf("step +%0d dac a", i), dac_dat_o[0], (i == 2) ? STEP_A : '0);
      check_val($sformatf("step +%0d dac b", i), dac_dat_o[1], (i == 2) ? STEP_B : '0);
      check_val($sformatf("step +%0d smp a", i), adc_smp_o[0], (i == 3) ? STEP_A : '0);
      check_val($sformatf("step +%0d smp b", i), adc_smp_o[1], (i == 3) ? STEP_B : '0);
    end
    close_test("latency");

    // directed rows, then lfsr rows
    for (int r = 0; r < TBL_ROWS + RAND_ROWS; r++)
    begin
      if (r < TBL_ROWS)
      begin
        v = table_row(r);
      end
      else
      begin
        make_rand_row(v);
      end
      @(posedge adc_clk);
      drive_row(v);
      repeat (HOLD_CYC - 1) @(posedge adc_clk);
      @(negedge adc_clk);  // all stages settled
      check_outputs($sformatf("row %0d", r), v);
      close_test($sformatf("%s row %0d", (r < TBL_ROWS) ? "table" : "random", r));
    end

    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             test_cnt, fail_cnt, checks, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
design/rp_analog_pkg.sv
design/adc_frontend.sv
design/analog_channel.sv
design/dac_backend.sv
design/analog_top.sv
verif/tb_analog_top.sv

// File: Bender.yml
package:
  name: rp_analog

dependencies: {}

sources:
  # package first, then the blocks, top level last
  - files:
      - design/rp_analog_pkg.sv
      - design/adc_frontend.sv
      - design/analog_channel.sv
      - design/dac_backend.sv
      - design/analog_top.sv

  # testbench with its vector table header
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_analog_top.sv
